//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 --Mdir obj_dir
TOP       := tb_soc_bus_top
FILELIST  := soc_bus_top.f
LOG       := sim.log
SOURCES   := $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/bus_pkg.sv
package bus_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0]  strb_t;
	typedef logic [2:0]  size_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_decerr = 2'b11;

	// Core-local timer window, inclusive on both ends.
	localparam addr_t clint_base = 32'h0200_0000;
	localparam addr_t clint_last = 32'h0200_ffff;

	typedef struct packed {
		addr_t addr;
		size_t size;
	} ar_req_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
	} r_rsp_t;

	typedef struct packed {
		word_t data;
		resp_t resp;
	} fetch_rsp_t;

	typedef struct packed {
		word_t data;
		resp_t resp;
	} word_rsp_t;

	typedef struct packed {
		addr_t addr;
		size_t size;
	} aw_req_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_req_t;

endpackage

//--- hw/bus_xbar.sv
`timescale 1ns/1ps

module bus_xbar (
	input  logic                 clock,
	input  logic                 rst_n,

	input  bus_pkg::ar_req_t     fetch_ar,
	input  logic                 fetch_ar_valid,
	output logic                 fetch_ar_ready,
	output bus_pkg::fetch_rsp_t  fetch_r,
	output logic                 fetch_r_valid,
	input  logic                 fetch_r_ready,

	input  bus_pkg::ar_req_t     lsu_ar,
	input  logic                 lsu_ar_valid,
	output logic                 lsu_ar_ready,
	output bus_pkg::r_rsp_t      lsu_r,
	output logic                 lsu_r_valid,
	input  logic                 lsu_r_ready,

	input  bus_pkg::aw_req_t     lsu_aw,
	input  bus_pkg::w_req_t      lsu_w,
	input  logic                 lsu_aw_valid,
	input  logic                 lsu_w_valid,
	output logic                 lsu_aw_ready,
	output logic                 lsu_w_ready,
	output bus_pkg::resp_t       lsu_b,
	output logic                 lsu_b_valid,
	input  logic                 lsu_b_ready,

	output bus_pkg::ar_req_t     mem_ar,
	output logic                 mem_ar_valid,
	input  logic                 mem_ar_ready,
	input  bus_pkg::r_rsp_t      mem_r,
	input  logic                 mem_r_valid,
	output logic                 mem_r_ready,

	output bus_pkg::aw_req_t     mem_aw,
	output bus_pkg::w_req_t      mem_w,
	output logic                 mem_aw_valid,
	output logic                 mem_w_valid,
	input  logic                 mem_aw_ready,
	input  logic                 mem_w_ready,
	input  bus_pkg::resp_t       mem_b,
	input  logic                 mem_b_valid,
	output logic                 mem_b_ready,

	output bus_pkg::addr_t       clint_ar,
	output logic                 clint_ar_valid,
	input  logic                 clint_ar_ready,
	input  bus_pkg::word_rsp_t   clint_r,
	input  logic                 clint_r_valid,
	output logic                 clint_r_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_fetch,
		st_lsu
	} xbar_state_t;

	xbar_state_t state_q, state_d;
	logic        ar_sent_q;
	logic        sel_clint_q;
	logic        addr2_q;
	logic        lsu_is_clint;
	logic        fetch_ar_hs, lsu_ar_hs, rd_done;

	assign lsu_is_clint = (lsu_ar.addr >= bus_pkg::clint_base) &&
	                      (lsu_ar.addr <= bus_pkg::clint_last);

	assign fetch_ar_hs = fetch_ar_valid && fetch_ar_ready;
	assign lsu_ar_hs   = lsu_ar_valid && lsu_ar_ready;
	assign rd_done     = (fetch_r_valid && fetch_r_ready) || (lsu_r_valid && lsu_r_ready);

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			st_idle: begin
				// Fetch has priority over load/store.
				if (fetch_ar_valid)
					state_d = st_fetch;
				else if (lsu_ar_valid)
					state_d = st_lsu;
			end
			st_fetch, st_lsu: begin
				if (rd_done)
					state_d = st_idle;
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= st_idle;
			ar_sent_q   <= 1'b0;
			sel_clint_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (rd_done)
				ar_sent_q <= 1'b0;
			else if (fetch_ar_hs || lsu_ar_hs)
				ar_sent_q <= 1'b1;
			if (fetch_ar_hs)
				sel_clint_q <= 1'b0;
			else if (lsu_ar_hs)
				sel_clint_q <= lsu_is_clint;
		end
	end

	// Selects the fetch word within the 64-bit beat.
	always_ff @(posedge clock) begin
		if (fetch_ar_hs)
			addr2_q <= fetch_ar.addr[2];
	end

	// One address per grant; the response routing uses the captured target.
	always_comb begin
		mem_ar         = '0;
		mem_ar_valid   = 1'b0;
		clint_ar       = '0;
		clint_ar_valid = 1'b0;
		fetch_ar_ready = 1'b0;
		lsu_ar_ready   = 1'b0;
		if (state_q == st_fetch && !ar_sent_q) begin
			mem_ar.addr    = fetch_ar.addr;
			mem_ar.size    = 3'd2;
			mem_ar_valid   = fetch_ar_valid;
			fetch_ar_ready = mem_ar_ready;
		end else if (state_q == st_lsu && !ar_sent_q) begin
			if (lsu_is_clint) begin
				clint_ar       = lsu_ar.addr;
				clint_ar_valid = lsu_ar_valid;
				lsu_ar_ready   = clint_ar_ready;
			end else begin
				mem_ar       = lsu_ar;
				mem_ar_valid = lsu_ar_valid;
				lsu_ar_ready = mem_ar_ready;
			end
		end
	end

	assign fetch_r.data  = addr2_q ? mem_r.data[63:32] : mem_r.data[31:0];
	assign fetch_r.resp  = mem_r.resp;
	assign fetch_r_valid = (state_q == st_fetch) && mem_r_valid;

	assign lsu_r.data  = sel_clint_q ? {32'b0, clint_r.data} : mem_r.data;
	assign lsu_r.resp  = sel_clint_q ? clint_r.resp : mem_r.resp;
	assign lsu_r_valid = (state_q == st_lsu) && (sel_clint_q ? clint_r_valid : mem_r_valid);

	assign mem_r_ready   = ((state_q == st_fetch) && fetch_r_ready) ||
	                       ((state_q == st_lsu) && !sel_clint_q && lsu_r_ready);
	assign clint_r_ready = (state_q == st_lsu) && sel_clint_q && lsu_r_ready;

	// Writes bypass the read arbiter entirely.
	assign mem_aw       = lsu_aw;
	assign mem_aw_valid = lsu_aw_valid;
	assign lsu_aw_ready = mem_aw_ready;
	assign mem_w        = lsu_w;
	assign mem_w_valid  = lsu_w_valid;
	assign lsu_w_ready  = mem_w_ready;
	assign lsu_b        = mem_b;
	assign lsu_b_valid  = mem_b_valid;
	assign mem_b_ready  = lsu_b_ready;

	// A stalled response keeps its grant and reaches the master unchanged.
	a_grant_held: assert property (@(posedge clock) disable iff (!rst_n)
		(fetch_r_valid && !fetch_r_ready) || (lsu_r_valid && !lsu_r_ready)
		|=> $stable(state_q) && $stable(fetch_r_valid) && $stable(lsu_r_valid) &&
			$stable(fetch_r) && $stable(lsu_r));

	a_one_reader: assert property (@(posedge clock) disable iff (!rst_n)
		!(fetch_ar_ready && lsu_ar_ready));

endmodule

//--- hw/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
	input  logic                clock,
	input  logic                rst_n,

	input  bus_pkg::addr_t      clint_ar,
	input  logic                clint_ar_valid,
	output logic                clint_ar_ready,
	output bus_pkg::word_rsp_t  clint_r,
	output logic                clint_r_valid,
	input  logic                clint_r_ready
);

	logic [63:0] mtime_q;
	logic        ar_hs;

	assign clint_ar_ready = !clint_r_valid;
	assign ar_hs          = clint_ar_valid && clint_ar_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			mtime_q <= '0;
		else
			mtime_q <= mtime_q + 64'd1;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			clint_r_valid <= 1'b0;
		end else begin
			if (ar_hs)
				clint_r_valid <= 1'b1;
			else if (clint_r_ready)
				clint_r_valid <= 1'b0;
		end
	end

	// Bit 2 picks the high half of mtime.
	always_ff @(posedge clock) begin
		if (ar_hs) begin
			clint_r.data <= clint_ar[2] ? mtime_q[63:32] : mtime_q[31:0];
			clint_r.resp <= bus_pkg::resp_okay;
		end
	end

endmodule

//--- hw/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
	parameter int mem_words = 256
) (
	input  logic              clock,
	input  logic              rst_n,

	input  bus_pkg::ar_req_t  mem_ar,
	input  logic              mem_ar_valid,
	output logic              mem_ar_ready,
	output bus_pkg::r_rsp_t   mem_r,
	output logic              mem_r_valid,
	input  logic              mem_r_ready,

	input  bus_pkg::aw_req_t  mem_aw,
	input  bus_pkg::w_req_t   mem_w,
	input  logic              mem_aw_valid,
	input  logic              mem_w_valid,
	output logic              mem_aw_ready,
	output logic              mem_w_ready,
	output bus_pkg::resp_t    mem_b,
	output logic              mem_b_valid,
	input  logic              mem_b_ready
);

	localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

	bus_pkg::data_t  mem [mem_words];
	bus_pkg::addr_t  ar_beat, aw_beat;
	logic            ar_in_range, aw_in_range;
	logic            ar_hs, wr_hs;

	// Beat index is the byte address divided by eight.
	assign ar_beat     = mem_ar.addr >> 3;
	assign aw_beat     = mem_aw.addr >> 3;
	assign ar_in_range = ar_beat < mem_words;
	assign aw_in_range = aw_beat < mem_words;

	assign mem_ar_ready = !mem_r_valid;
	assign ar_hs        = mem_ar_valid && mem_ar_ready;

	// Address and data are taken in the same cycle.
	assign wr_hs        = mem_aw_valid && mem_w_valid && !mem_b_valid;
	assign mem_aw_ready = wr_hs;
	assign mem_w_ready  = wr_hs;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mem_r_valid <= 1'b0;
			mem_b_valid <= 1'b0;
		end else begin
			if (ar_hs)
				mem_r_valid <= 1'b1;
			else if (mem_r_ready)
				mem_r_valid <= 1'b0;
			if (wr_hs)
				mem_b_valid <= 1'b1;
			else if (mem_b_ready)
				mem_b_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_hs) begin
			if (ar_in_range) begin
				mem_r.data <= mem[ar_beat[idx_w-1:0]];
				mem_r.resp <= bus_pkg::resp_okay;
			end else begin
				mem_r.data <= '0;
				mem_r.resp <= bus_pkg::resp_decerr;
			end
		end
		if (wr_hs)
			mem_b <= aw_in_range ? bus_pkg::resp_okay : bus_pkg::resp_decerr;
	end

	// Byte lanes without a strobe keep their old contents.
	always_ff @(posedge clock) begin
		if (wr_hs && aw_in_range) begin
			for (int i = 0; i < $bits(bus_pkg::strb_t); i++) begin
				if (mem_w.strb[i])
					mem[aw_beat[idx_w-1:0]][i*8 +: 8] <= mem_w.data[i*8 +: 8];
			end
		end
	end

	a_r_held: assert property (@(posedge clock) disable iff (!rst_n)
		mem_r_valid && !mem_r_ready |=> mem_r_valid && $stable(mem_r));

endmodule

//--- hw/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top #(
	parameter int mem_words = 256
) (
	input  logic                 clock,
	input  logic                 rst_n,

	input  bus_pkg::ar_req_t     fetch_ar,
	input  logic                 fetch_ar_valid,
	output logic                 fetch_ar_ready,
	output bus_pkg::fetch_rsp_t  fetch_r,
	output logic                 fetch_r_valid,
	input  logic                 fetch_r_ready,

	input  bus_pkg::ar_req_t     lsu_ar,
	input  logic                 lsu_ar_valid,
	output logic                 lsu_ar_ready,
	output bus_pkg::r_rsp_t      lsu_r,
	output logic                 lsu_r_valid,
	input  logic                 lsu_r_ready,

	input  bus_pkg::aw_req_t     lsu_aw,
	input  bus_pkg::w_req_t      lsu_w,
	input  logic                 lsu_aw_valid,
	input  logic                 lsu_w_valid,
	output logic                 lsu_aw_ready,
	output logic                 lsu_w_ready,
	output bus_pkg::resp_t       lsu_b,
	output logic                 lsu_b_valid,
	input  logic                 lsu_b_ready
);

	bus_pkg::ar_req_t    mem_ar;
	logic                mem_ar_valid, mem_ar_ready;
	bus_pkg::r_rsp_t     mem_r;
	logic                mem_r_valid, mem_r_ready;
	bus_pkg::aw_req_t    mem_aw;
	bus_pkg::w_req_t     mem_w;
	logic                mem_aw_valid, mem_w_valid;
	logic                mem_aw_ready, mem_w_ready;
	bus_pkg::resp_t      mem_b;
	logic                mem_b_valid, mem_b_ready;
	bus_pkg::addr_t      clint_ar;
	logic                clint_ar_valid, clint_ar_ready;
	bus_pkg::word_rsp_t  clint_r;
	logic                clint_r_valid, clint_r_ready;

	bus_xbar u_xbar (
		.clock          (clock),
		.rst_n          (rst_n),
		.fetch_ar       (fetch_ar),
		.fetch_ar_valid (fetch_ar_valid),
		.fetch_ar_ready (fetch_ar_ready),
		.fetch_r        (fetch_r),
		.fetch_r_valid  (fetch_r_valid),
		.fetch_r_ready  (fetch_r_ready),
		.lsu_ar         (lsu_ar),
		.lsu_ar_valid   (lsu_ar_valid),
		.lsu_ar_ready   (lsu_ar_ready),
		.lsu_r          (lsu_r),
		.lsu_r_valid    (lsu_r_valid),
		.lsu_r_ready    (lsu_r_ready),
		.lsu_aw         (lsu_aw),
		.lsu_w          (lsu_w),
		.lsu_aw_valid   (lsu_aw_valid),
		.lsu_w_valid    (lsu_w_valid),
		.lsu_aw_ready   (lsu_aw_ready),
		.lsu_w_ready    (lsu_w_ready),
		.lsu_b          (lsu_b),
		.lsu_b_valid    (lsu_b_valid),
		.lsu_b_ready    (lsu_b_ready),
		.mem_ar         (mem_ar),
		.mem_ar_valid   (mem_ar_valid),
		.mem_ar_ready   (mem_ar_ready),
		.mem_r          (mem_r),
		.mem_r_valid    (mem_r_valid),
		.mem_r_ready    (mem_r_ready),
		.mem_aw         (mem_aw),
		.mem_w          (mem_w),
		.mem_aw_valid   (mem_aw_valid),
		.mem_w_valid    (mem_w_valid),
		.mem_aw_ready   (mem_aw_ready),
		.mem_w_ready    (mem_w_ready),
		.mem_b          (mem_b),
		.mem_b_valid    (mem_b_valid),
		.mem_b_ready    (mem_b_ready),
		.clint_ar       (clint_ar),
		.clint_ar_valid (clint_ar_valid),
		.clint_ar_ready (clint_ar_ready),
		.clint_r        (clint_r),
		.clint_r_valid  (clint_r_valid),
		.clint_r_ready  (clint_r_ready)
	);

	data_mem #(
		.mem_words (mem_words)
	) u_mem (
		.clock        (clock),
		.rst_n        (rst_n),
		.mem_ar       (mem_ar),
		.mem_ar_valid (mem_ar_valid),
		.mem_ar_ready (mem_ar_ready),
		.mem_r        (mem_r),
		.mem_r_valid  (mem_r_valid),
		.mem_r_ready  (mem_r_ready),
		.mem_aw       (mem_aw),
		.mem_w        (mem_w),
		.mem_aw_valid (mem_aw_valid),
		.mem_w_valid  (mem_w_valid),
		.mem_aw_ready (mem_aw_ready),
		.mem_w_ready  (mem_w_ready),
		.mem_b        (mem_b),
		.mem_b_valid  (mem_b_valid),
		.mem_b_ready  (mem_b_ready)
	);

	clint_timer u_clint (
		.clock          (clock),
		.rst_n          (rst_n),
		.clint_ar       (clint_ar),
		.clint_ar_valid (clint_ar_valid),
		.clint_ar_ready (clint_ar_ready),
		.clint_r        (clint_r),
		.clint_r_valid  (clint_r_valid),
		.clint_r_ready  (clint_r_ready)
	);

endmodule

//--- soc_bus_top.f
+incdir+test
hw/bus_pkg.sv
hw/clint_timer.sv
hw/data_mem.sv
hw/bus_xbar.sv
hw/soc_bus_top.sv
test/tb_soc_bus_top.sv

//--- test/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;
int other_errors = 0;

task automatic check_fetch(input string name, input bus_pkg::fetch_rsp_t exp,
		input bus_pkg::fetch_rsp_t act);
	if (act !== exp) begin
		value_errors++;
		$display("FAILED %s: expected data %h resp %0d, actual data %h resp %0d",
			name, exp.data, exp.resp, act.data, act.resp);
	end
endtask

task automatic check_beat(input string name, input bus_pkg::r_rsp_t exp,
		input bus_pkg::r_rsp_t act);
	if (act !== exp) begin
		value_errors++;
		$display("FAILED %s: expected data %h resp %0d, actual data %h resp %0d",
			name, exp.data, exp.resp, act.data, act.resp);
	end
endtask

task automatic check_resp(input string name, input bus_pkg::resp_t exp,
		input bus_pkg::resp_t act);
	if (act !== exp) begin
		value_errors++;
		$display("FAILED %s: expected resp %0d, actual resp %0d", name, exp, act);
	end
endtask

task automatic check_word(input string name, input bus_pkg::word_t exp,
		input bus_pkg::word_t act);
	if (act !== exp) begin
		value_errors++;
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic note_failure(input string what);
	other_errors++;
	$display("ERROR: %s", what);
endtask

`endif

//--- test/tb_soc_bus_top.sv
`timescale 1ns/1ps

module tb_soc_bus_top;

	localparam int mem_words = 256;
	localparam int n_writes  = 64;
	localparam int n_fetch   = 32;
	localparam int n_conc    = 32;
	localparam int n_timer   = 16;
	localparam int n_bad     = 8;
	// Every bad address costs a write, a read, a fetch and a readback.
	localparam int n_ops = mem_words + 2 * n_writes + n_fetch + 2 * n_conc +
		2 * n_timer + 4 * n_bad;
	localparam int timeout_cycles = n_ops * 40 + 1000;

	logic                clock;
	logic                rst_n;
	bus_pkg::ar_req_t    fetch_ar;
	logic                fetch_ar_valid, fetch_ar_ready;
	bus_pkg::fetch_rsp_t fetch_r;
	logic                fetch_r_valid, fetch_r_ready;
	bus_pkg::ar_req_t    lsu_ar;
	logic                lsu_ar_valid, lsu_ar_ready;
	bus_pkg::r_rsp_t     lsu_r;
	logic                lsu_r_valid, lsu_r_ready;
	bus_pkg::aw_req_t    lsu_aw;
	bus_pkg::w_req_t     lsu_w;
	logic                lsu_aw_valid, lsu_w_valid, lsu_aw_ready, lsu_w_ready;
	bus_pkg::resp_t      lsu_b;
	logic                lsu_b_valid, lsu_b_ready;

	// Reference memory, one entry per 64-bit beat.
	bus_pkg::data_t model [int];
	int fetch_seen = 0;
	int lsu_seen   = 0;

	`include "tb_checks.svh"

	soc_bus_top #(
		.mem_words (mem_words)
	) u_soc_bus_top (.*);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	// Read response handshakes as seen on the bus.
	always @(posedge clock) begin
		if (fetch_r_valid && fetch_r_ready)
			fetch_seen++;
		if (lsu_r_valid && lsu_r_ready)
			lsu_seen++;
	end

	function automatic bus_pkg::data_t fill_value(input bus_pkg::addr_t addr);
		return {addr ^ 32'h5a5a_c3c3, ~addr};
	endfunction

	function automatic bus_pkg::data_t merge_bytes(input bus_pkg::data_t old,
			input bus_pkg::data_t wdata, input bus_pkg::strb_t strb);
		bus_pkg::data_t merged;
		merged = old;
		for (int b = 0; b < 8; b++) begin
			if (strb[b])
				merged[8*b +: 8] = wdata[8*b +: 8];
		end
		return merged;
	endfunction

	function automatic bus_pkg::r_rsp_t expected_beat(input bus_pkg::addr_t addr);
		bus_pkg::r_rsp_t exp;
		int beat;
		beat = addr >> 3;
		if (beat >= mem_words) begin
			exp.data = '0;
			exp.resp = bus_pkg::resp_decerr;
		end else begin
			exp.data = model[beat];
			exp.resp = bus_pkg::resp_okay;
		end
		return exp;
	endfunction

	function automatic bus_pkg::fetch_rsp_t expected_fetch(input bus_pkg::addr_t addr);
		bus_pkg::r_rsp_t beat;
		bus_pkg::fetch_rsp_t exp;
		beat = expected_beat(addr);
		exp.data = addr[2] ? beat.data[63:32] : beat.data[31:0];
		exp.resp = beat.resp;
		return exp;
	endfunction

	// Outputs are sampled 1 ns after the falling edge, once inputs have settled.
	task automatic fetch_read(input bus_pkg::addr_t addr, output bus_pkg::fetch_rsp_t rsp);
		int unsigned gap;
		gap = $urandom_range(3, 0);
		@(negedge clock);
		fetch_ar.addr = addr;
		fetch_ar.size = 3'd2;
		fetch_ar_valid = 1'b1;
		#1;
		while (!fetch_ar_ready) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		fetch_ar_valid = 1'b0;
		fetch_r_ready = (gap == 0);
		#1;
		while (!(fetch_r_valid && fetch_r_ready)) begin
			if (fetch_r_valid)
				gap--;
			@(negedge clock);
			fetch_r_ready = (gap == 0);
			#1;
		end
		rsp = fetch_r;
		@(negedge clock);
		fetch_r_ready = 1'b0;
		#1;
		if (fetch_r_valid)
			note_failure("fetch response stayed valid after its handshake");
	endtask

	task automatic lsu_read(input bus_pkg::addr_t addr, output bus_pkg::r_rsp_t rsp);
		int unsigned gap;
		gap = $urandom_range(3, 0);
		@(negedge clock);
		lsu_ar.addr = addr;
		lsu_ar.size = 3'd3;
		lsu_ar_valid = 1'b1;
		#1;
		while (!lsu_ar_ready) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		lsu_ar_valid = 1'b0;
		lsu_r_ready = (gap == 0);
		#1;
		while (!(lsu_r_valid && lsu_r_ready)) begin
			if (lsu_r_valid)
				gap--;
			@(negedge clock);
			lsu_r_ready = (gap == 0);
			#1;
		end
		rsp = lsu_r;
		@(negedge clock);
		lsu_r_ready = 1'b0;
		#1;
		if (lsu_r_valid)
			note_failure("load response stayed valid after its handshake");
	endtask

	task automatic lsu_write(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
			input bus_pkg::strb_t strb, output bus_pkg::resp_t rsp);
		int unsigned gap;
		gap = $urandom_range(3, 0);
		@(negedge clock);
		lsu_aw.addr = addr;
		lsu_aw.size = 3'd3;
		lsu_w.data = data;
		lsu_w.strb = strb;
		lsu_aw_valid = 1'b1;
		lsu_w_valid = 1'b1;
		#1;
		while (!(lsu_aw_ready && lsu_w_ready)) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		lsu_aw_valid = 1'b0;
		lsu_w_valid = 1'b0;
		lsu_b_ready = (gap == 0);
		#1;
		while (!(lsu_b_valid && lsu_b_ready)) begin
			if (lsu_b_valid)
				gap--;
			@(negedge clock);
			lsu_b_ready = (gap == 0);
			#1;
		end
		rsp = lsu_b;
		@(negedge clock);
		lsu_b_ready = 1'b0;
		#1;
		if (lsu_b_valid)
			note_failure("write response stayed valid after its handshake");
	endtask

	initial begin
		bus_pkg::fetch_rsp_t frsp;
		bus_pkg::r_rsp_t     rrsp;
		bus_pkg::resp_t      bresp;
		bus_pkg::addr_t      a, b;
		bus_pkg::data_t      d;
		bus_pkg::strb_t      s;
		bus_pkg::word_t      last_time;
		int                  idx, idx2;
		int                  written [$];

		void'($urandom(89272));
		rst_n = 1'b0;
		fetch_ar = '0;
		fetch_ar_valid = 1'b0;
		fetch_r_ready = 1'b0;
		lsu_ar = '0;
		lsu_ar_valid = 1'b0;
		lsu_r_ready = 1'b0;
		lsu_aw = '0;
		lsu_w = '0;
		lsu_aw_valid = 1'b0;
		lsu_w_valid = 1'b0;
		lsu_b_ready = 1'b0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		// Full-strobe fill so that every byte of the model is known.
		for (int i = 0; i < mem_words; i++) begin
			a = bus_pkg::addr_t'(i) << 3;
			model[i] = fill_value(a);
			lsu_write(a, model[i], 8'hff, bresp);
			check_resp("fill write", bus_pkg::resp_okay, bresp);
		end

		for (int i = 0; i < n_writes; i++) begin
			idx = $urandom_range(mem_words - 1, 0);
			a = bus_pkg::addr_t'(idx) << 3;
			d = {$urandom, $urandom};
			s = bus_pkg::strb_t'($urandom);
			lsu_write(a, d, s, bresp);
			check_resp("random write", bus_pkg::resp_okay, bresp);
			model[idx] = merge_bytes(model[idx], d, s);
			written.push_back(idx);
		end
		foreach (written[i]) begin
			a = bus_pkg::addr_t'(written[i]) << 3;
			lsu_read(a, rrsp);
			check_beat("read back", expected_beat(a), rrsp);
		end

		for (int i = 0; i < n_fetch; i++) begin
			idx = $urandom_range(mem_words - 1, 0);
			a = (bus_pkg::addr_t'(idx) << 3) | (bus_pkg::addr_t'($urandom_range(1, 0)) << 2);
			fetch_read(a, frsp);
			check_fetch("fetch word", expected_fetch(a), frsp);
		end

		fetch_seen = 0;
		lsu_seen = 0;
		for (int i = 0; i < n_conc; i++) begin
			idx = $urandom_range(mem_words - 1, 0);
			idx2 = (idx + 1 + $urandom_range(mem_words - 2, 0)) % mem_words;
			a = (bus_pkg::addr_t'(idx) << 3) | (bus_pkg::addr_t'(i & 1) << 2);
			b = bus_pkg::addr_t'(idx2) << 3;
			fork
				fetch_read(a, frsp);
				lsu_read(b, rrsp);
			join
			check_fetch("concurrent fetch", expected_fetch(a), frsp);
			check_beat("concurrent load", expected_beat(b), rrsp);
		end
		if (fetch_seen != n_conc || lsu_seen != n_conc)
			note_failure($sformatf("concurrent reads got %0d fetch and %0d load responses for %0d each",
				fetch_seen, lsu_seen, n_conc));

		last_time = '0;
		for (int i = 0; i < n_timer; i++) begin
			lsu_read(bus_pkg::clint_base, rrsp);
			check_resp("timer low resp", bus_pkg::resp_okay, rrsp.resp);
			check_word("timer low upper half", '0, rrsp.data[63:32]);
			if (i > 0 && rrsp.data[31:0] <= last_time)
				note_failure($sformatf("timer went from %0d to %0d", last_time, rrsp.data[31:0]));
			last_time = rrsp.data[31:0];
			lsu_read(bus_pkg::clint_base + 32'd4, rrsp);
			check_resp("timer high resp", bus_pkg::resp_okay, rrsp.resp);
			check_word("timer high word", '0, rrsp.data[31:0]);
		end

		// The first bad address sits right past the end of memory.
		for (int i = 0; i < n_bad; i++) begin
			if (i == 0)
				b = bus_pkg::addr_t'(mem_words) << 3;
			else
				b = 32'h8000_0000 | ($urandom & 32'h7fff_fff8);
			idx = (b >> 3) % mem_words;
			lsu_write(b, {$urandom, $urandom}, 8'hff, bresp);
			check_resp("bad write", bus_pkg::resp_decerr, bresp);
			lsu_read(b, rrsp);
			check_beat("bad read", expected_beat(b), rrsp);
			fetch_read(b | 32'h4, frsp);
			check_fetch("bad fetch", expected_fetch(b | 32'h4), frsp);
			a = bus_pkg::addr_t'(idx) << 3;
			lsu_read(a, rrsp);
			check_beat("dropped write", expected_beat(a), rrsp);
		end

		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clock);
		$display("Watchdog expired after %0d cycles, a handshake never completed",
			timeout_cycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
